// File: logic/getFeaturesConsts.svh
`ifndef GET_FEATURES_CONSTS_SVH
`define GET_FEATURES_CONSTS_SVH

// command decode
`define GF_OPCODE           6'b100101
`define GF_TARGET_ID        5'b00101

// flash command bytes
`define GF_FLASH_CMD        8'hEE
`define GF_FLASH_CMD_LUN    8'hD4   // LUN get features

// step counts
`define GF_TIMER1_COUNT     16'd149 // about 1500 ns
`define GF_DATA_IN_COUNT    16'd7   // eight bytes
`define GF_TIMER2_COUNT     16'd3

// PM command options
`define GF_OPT_CE_ON        3'b001
`define GF_OPT_BYTE_IN      3'b000
`define GF_OPT_TIMER2       3'b100

// bit positions in the one-hot PM command and last-step vectors
`define GF_PM_TIMER         0
`define GF_PM_DATA_IN       1
`define GF_PM_CAL           3

// low PM ready bits that must all be set
`define GF_PM_READY_BITS    7

`define GF_NUM_WAYS         4

`endif

// File: logic/getFeaturesPkg.sv
`default_nettype none

`include "getFeaturesConsts.svh"

package getFeaturesPkg;

    // steps requested from the PM, in order
    typedef enum logic [3:0] {
        idle,
        calStart,
        calCommand,
        calAddress,
        timer1,
        dataIn,
        timer2,
        timerWait,
        finish
    } stepPhase_t;

    typedef enum logic [2:0] {
        collectIdle,
        collectStandby0,
        collectCapture0,
        collectStandby1,
        collectCapture1,
        collectTransfer,
        collectWait
    } collectState_t;

    typedef logic [7:0] pmCommand_t;    // one-hot
    typedef logic [2:0] pmOption_t;
    typedef logic [15:0] pmCount_t;
    typedef logic [`GF_NUM_WAYS-1:0] way_t;
    typedef logic [31:0] word_t;

endpackage

`default_nettype wire

// File: logic/sequencerStepIf.sv
`timescale 1ns/1ps
`default_nettype none

interface sequencerStepIf;
    import getFeaturesPkg::*;

    stepPhase_t phase;  // next phase, registered by the issuer
    logic capture;      // request accepted this cycle
    logic accepted;     // PM took the current step
    logic timerDone;

    modport sequencer (
        output phase,
        output capture,
        input accepted,
        input timerDone
    );

    modport issuer (
        input phase,
        input capture,
        output accepted,
        output timerDone
    );

endinterface

`default_nettype wire

// File: logic/featureSequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "getFeaturesConsts.svh"

module featureSequencer (
    input wire logic iSystemClock,
    input wire logic iReset,
    input wire logic [5:0] opcode,
    input wire logic [4:0] targetId,
    input wire logic cmdValid,
    output logic cmdReady,
    output logic start,
    input wire logic collectDone,
    output logic lastStep,
    sequencerStepIf.sequencer step
);
    import getFeaturesPkg::*;

    stepPhase_t phaseNow;
    stepPhase_t phaseNext;
    logic commandMatch;
    logic armed;    // one idle cycle after reset before taking commands

    assign commandMatch = (opcode == `GF_OPCODE) && (targetId == `GF_TARGET_ID);
    assign start = cmdValid && commandMatch && cmdReady;
    assign lastStep = (phaseNow == finish) && collectDone;

    always_comb begin
        phaseNext = phaseNow;
        unique case (phaseNow)
            idle: begin
                if (start) begin
                    phaseNext = calStart;
                end
            end
            calStart: begin
                if (step.accepted) begin
                    phaseNext = calCommand;
                end
            end
            calCommand: begin
                phaseNext = calAddress;
            end
            calAddress: begin
                phaseNext = timer1;
            end
            timer1: begin
                if (step.accepted) begin
                    phaseNext = dataIn;
                end
            end
            dataIn: begin
                if (step.accepted) begin
                    phaseNext = timer2;
                end
            end
            timer2: begin
                if (step.accepted) begin
                    phaseNext = timerWait;
                end
            end
            timerWait: begin
                if (step.timerDone) begin
                    phaseNext = finish;
                end
            end
            finish: begin
                if (lastStep) begin
                    phaseNext = idle;
                end
            end
            default: begin
                phaseNext = idle;
            end
        endcase
    end

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            phaseNow <= idle;
            armed <= 1'b0;
            cmdReady <= 1'b0;
        end else begin
            phaseNow <= phaseNext;
            armed <= 1'b1;
            cmdReady <= armed && (phaseNext == idle); // drops on start
        end
    end

    // issuer works from the next phase so its fields line up with phaseNow
    assign step.phase = phaseNext;
    assign step.capture = start;

endmodule

`default_nettype wire

// File: logic/primitiveIssuer.sv
`timescale 1ns/1ps
`default_nettype none

`include "getFeaturesConsts.svh"

module primitiveIssuer (
    input wire logic iSystemClock,
    input wire logic iReset,
    input wire logic [4:0] sourceId,
    input wire logic [7:0] length,
    input wire getFeaturesPkg::way_t waySelect,
    input wire logic [7:0] pmReady,
    input wire logic [7:0] pmLastStep,
    output getFeaturesPkg::pmCommand_t pmCommand,
    output getFeaturesPkg::pmOption_t pmCommandOption,
    output getFeaturesPkg::way_t pmTargetWay,
    output getFeaturesPkg::pmCount_t pmNumOfData,
    output logic pmCaSelect,
    output logic [7:0] pmCaData,
    sequencerStepIf.issuer step
);
    import getFeaturesPkg::*;

    logic lunSelect;
    logic [1:0] lunAddress;
    logic [7:0] lengthReg;
    logic lunRequest;
    logic pmAllReady;
    pmCommand_t commandNext;
    pmOption_t optionNext;
    pmCount_t countNext;
    logic caSelectNext;
    logic [7:0] caDataNext;

    // capture cycle still sees the live source ID
    assign lunRequest = step.capture ? sourceId[0] : lunSelect;
    assign pmAllReady = &pmReady[`GF_PM_READY_BITS-1:0];

    always_comb begin
        commandNext = '0;
        caSelectNext = 1'b0;
        optionNext = pmCommandOption;
        countNext = pmNumOfData;
        caDataNext = pmCaData;
        unique case (step.phase)
            calStart: begin
                commandNext = 8'b1 << `GF_PM_CAL;
                optionNext = '0;
                countNext = lunRequest ? 16'd2 : 16'd1;
            end
            calCommand: caDataNext = lunRequest ? `GF_FLASH_CMD_LUN : `GF_FLASH_CMD;
            calAddress: begin
                caSelectNext = 1'b1;
                caDataNext = lunRequest ? {6'b0, lunAddress} : lengthReg;
            end
            timer1: begin
                commandNext = 8'b1 << `GF_PM_TIMER;
                optionNext = `GF_OPT_CE_ON;
                countNext = `GF_TIMER1_COUNT;
            end
            dataIn: begin
                commandNext = 8'b1 << `GF_PM_DATA_IN;
                optionNext = `GF_OPT_BYTE_IN;
                countNext = `GF_DATA_IN_COUNT;
            end
            timer2: begin
                commandNext = 8'b1 << `GF_PM_TIMER;
                optionNext = `GF_OPT_TIMER2;
                countNext = `GF_TIMER2_COUNT;
            end
            default: ;  // no PM step
        endcase
    end

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            pmCommand <= '0;
            pmCaSelect <= 1'b0;
        end else begin
            pmCommand <= commandNext;
            pmCaSelect <= caSelectNext;
        end
    end

    always_ff @(posedge iSystemClock) begin
        if (step.capture) begin
            lunSelect <= sourceId[0];
            lunAddress <= sourceId[2:1];
            lengthReg <= length;
            pmTargetWay <= waySelect;
        end
        pmCommandOption <= optionNext;
        pmNumOfData <= countNext;
        pmCaData <= caDataNext;
    end

    assign step.accepted = (pmCommand != '0) && pmAllReady;
    assign step.timerDone = pmLastStep[`GF_PM_TIMER];

endmodule

`default_nettype wire

// File: logic/featureCollector.sv
`timescale 1ns/1ps
`default_nettype none

module featureCollector (
    input wire logic iSystemClock,
    input wire logic iReset,
    input wire logic start,
    input wire logic lastStep,
    output logic collectDone,
    input wire getFeaturesPkg::word_t pmReadData,
    input wire logic pmReadValid,
    output logic pmReadReady,
    output getFeaturesPkg::word_t readData,
    output logic readLast,
    output logic readValid,
    input wire logic readReady
);
    import getFeaturesPkg::*;

    collectState_t stateNow;
    collectState_t stateNext;
    logic beatTaken;
    logic [15:0] paramPair;    // bytes 3 and 1 of a PM beat

    assign beatTaken = pmReadValid && pmReadReady;
    assign paramPair = {pmReadData[31:24], pmReadData[15:8]};

    always_comb begin
        stateNext = stateNow;
        unique case (stateNow)
            collectIdle: if (start) stateNext = collectStandby0;
            collectStandby0: if (beatTaken) stateNext = collectCapture0;
            collectCapture0: begin
                stateNext = beatTaken ? collectCapture1 : collectStandby1;
            end
            collectStandby1: if (beatTaken) stateNext = collectCapture1;
            collectCapture1: stateNext = collectTransfer;
            collectTransfer: if (readReady) stateNext = collectWait;
            collectWait: if (lastStep) stateNext = collectIdle;
            default: stateNext = collectIdle;
        endcase
    end

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            stateNow <= collectIdle;
            pmReadReady <= 1'b0;
            readValid <= 1'b0;
        end else begin
            stateNow <= stateNext;
            pmReadReady <= (stateNext == collectStandby0) ||
                           (stateNext == collectCapture0) ||
                           (stateNext == collectStandby1);
            readValid <= (stateNext == collectTransfer);
        end
    end

    // beat 0 fills the low half, beat 1 the high half
    always_ff @(posedge iSystemClock) begin
        if (stateNext == collectCapture0) begin
            readData[15:0] <= paramPair;
        end
        if (stateNext == collectCapture1) begin
            readData[31:16] <= paramPair;
        end
    end

    assign readLast = readValid;    // the only beat is also the last
    assign collectDone = (stateNow == collectWait);

endmodule

`default_nettype wire

// File: logic/getFeaturesTop.sv
`timescale 1ns/1ps
`default_nettype none

module getFeaturesTop (
    input wire logic iSystemClock,
    input wire logic iReset,
    input wire logic [5:0] opcode,
    input wire logic [4:0] targetId,
    input wire logic [4:0] sourceId,
    input wire logic [7:0] length,
    input wire logic cmdValid,
    output logic cmdReady,
    output getFeaturesPkg::word_t readData,
    output logic readLast,
    output logic readValid,
    input wire logic readReady,
    input wire getFeaturesPkg::way_t waySelect,
    output logic start,
    output logic lastStep,
    input wire logic [7:0] pmReady,
    input wire logic [7:0] pmLastStep,
    output getFeaturesPkg::pmCommand_t pmCommand,
    output getFeaturesPkg::pmOption_t pmCommandOption,
    output getFeaturesPkg::way_t pmTargetWay,
    output getFeaturesPkg::pmCount_t pmNumOfData,
    output logic pmCaSelect,
    output logic [7:0] pmCaData,
    input wire getFeaturesPkg::word_t pmReadData,
    input wire logic pmReadValid,
    output logic pmReadReady
);
    logic collectDone;

    sequencerStepIf stepBus ();

    featureSequencer sequencer (
        .iSystemClock(iSystemClock),
        .iReset(iReset),
        .opcode(opcode),
        .targetId(targetId),
        .cmdValid(cmdValid),
        .cmdReady(cmdReady),
        .start(start),
        .collectDone(collectDone),
        .lastStep(lastStep),
        .step(stepBus.sequencer)
    );

    primitiveIssuer issuer (
        .iSystemClock(iSystemClock),
        .iReset(iReset),
        .sourceId(sourceId),
        .length(length),
        .waySelect(waySelect),
        .pmReady(pmReady),
        .pmLastStep(pmLastStep),
        .pmCommand(pmCommand),
        .pmCommandOption(pmCommandOption),
        .pmTargetWay(pmTargetWay),
        .pmNumOfData(pmNumOfData),
        .pmCaSelect(pmCaSelect),
        .pmCaData(pmCaData),
        .step(stepBus.issuer)
    );

    featureCollector collector (
        .iSystemClock(iSystemClock),
        .iReset(iReset),
        .start(start),
        .lastStep(lastStep),
        .collectDone(collectDone),
        .pmReadData(pmReadData),
        .pmReadValid(pmReadValid),
        .pmReadReady(pmReadReady),
        .readData(readData),
        .readLast(readLast),
        .readValid(readValid),
        .readReady(readReady)
    );

endmodule

`default_nettype wire

// File: tests/getFeatures_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "getFeaturesConsts.svh"

module getFeaturesSva (
    input wire logic iSystemClock,
    input wire logic iReset,
    input wire logic cmdReady,
    input wire logic start,
    input wire logic lastStep,
    input wire logic [7:0] pmReady,
    input wire getFeaturesPkg::pmCommand_t pmCommand,
    input wire getFeaturesPkg::pmOption_t pmCommandOption,
    input wire getFeaturesPkg::pmCount_t pmNumOfData,
    input wire getFeaturesPkg::way_t pmTargetWay,
    input wire getFeaturesPkg::word_t readData,
    input wire logic readValid,
    input wire logic readLast,
    input wire logic readReady
);
    int failureCount = 0;

    // PM step waits for ready
    assert property (@(posedge iSystemClock) disable iff (iReset)
        (pmCommand != '0 && !(&pmReady[`GF_PM_READY_BITS-1:0])) |=>
            $stable(pmCommand) && $stable(pmCommandOption) &&
            $stable(pmNumOfData) && $stable(pmTargetWay))
        else begin
            failureCount <= failureCount + 1;
            $error("PM step changed while pmReady was low");
        end

    assert property (@(posedge iSystemClock) disable iff (iReset)
        start |=> !cmdReady && (pmCommand == (8'b1 << `GF_PM_CAL)))
        else begin
            failureCount <= failureCount + 1;
            $error("no CAL step or cmdReady still high after start");
        end

    assert property (@(posedge iSystemClock) disable iff (iReset)
        lastStep |=> cmdReady)
        else begin
            failureCount <= failureCount + 1;
            $error("cmdReady not back the cycle after lastStep");
        end

    // read beat holds under back-pressure
    assert property (@(posedge iSystemClock) disable iff (iReset)
        (readValid && !readReady) |=> readValid && readLast && $stable(readData))
        else begin
            failureCount <= failureCount + 1;
            $error("read beat changed before readReady");
        end

endmodule

`default_nettype wire

// File: tests/getFeaturesTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "getFeaturesConsts.svh"

module getFeaturesTb;
    import getFeaturesPkg::*;

    localparam int NumRequests = 24;
    localparam int TimeoutCycles = NumRequests * 200 + 1000;

    logic iSystemClock;
    logic iReset;
    logic [5:0] opcode;
    logic [4:0] targetId;
    logic [4:0] sourceId;
    logic [7:0] length;
    logic cmdValid;
    way_t waySelect;
    logic readReady = 1'b0;
    logic [7:0] pmReady = '0;
    logic [7:0] pmLastStep = '0;
    word_t pmReadData = '0;
    logic pmReadValid = 1'b0;
    logic cmdReady, readLast, readValid, start, lastStep;
    logic pmCaSelect, pmReadReady;
    logic [7:0] pmCaData;
    word_t readData;
    pmCommand_t pmCommand;
    pmOption_t pmCommandOption;
    way_t pmTargetWay;
    pmCount_t pmNumOfData;

    logic [31:0] lfsrState = 32'hc587_5aba;
    logic [31:0] readyDelay = '0;
    logic [31:0] timerDelay = '0;
    logic [31:0] readGap = '0;
    logic [31:0] beatsSent = 32'd2;   // idle until a start
    word_t beat0 = '0;
    word_t beat1 = '0;
    int cycleCount = 0;
    int requestIndex = 0;
    int stepIndex = 0;
    int afterCal = 0;
    int readBeats = 0;
    logic commandMatches = 1'b1;
    logic expLun = 1'b0;
    logic [7:0] expCmdByte = '0;
    logic [7:0] expAddr = '0;
    way_t expWay = '0;
    pmCommand_t expCommand;
    pmOption_t expOption;
    pmCount_t expCount;
    word_t expWord;

    getFeaturesTop dut (.*);

    bind getFeaturesTop getFeaturesSva assertions (
        .iSystemClock(iSystemClock), .iReset(iReset), .cmdReady(cmdReady),
        .start(start), .lastStep(lastStep), .pmReady(pmReady), .pmCommand(pmCommand),
        .pmCommandOption(pmCommandOption), .pmNumOfData(pmNumOfData),
        .pmTargetWay(pmTargetWay), .readData(readData), .readValid(readValid),
        .readLast(readLast), .readReady(readReady)
    );

    // fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] result;
        logic feedback;
        int i;
        result = '0;
        for (i = 0; i < count; i++) begin
            feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};
            result = {result[30:0], feedback};
        end
        return result;
    endfunction

    task automatic reportMismatch(input string testName, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("** Error: %s (request %0d) expected %0h actual %0h",
                 testName, requestIndex, expected, actual);
        $display("Result: FAILED");
        $fatal(1, "value check failed");
    endtask

    initial begin
        iSystemClock = 1'b0;
        forever #20 iSystemClock = ~iSystemClock;
    end

    always @(posedge iSystemClock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end else if (dut.assertions.failureCount != 0) begin
            $display("A bound assertion failed, see the message above");
            $display("Result: FAILED");
            $fatal(1, "assertion failure");
        end
    end

    // PM model and read back-pressure
    always @(posedge iSystemClock) begin
        if (pmCommand != '0 && (&pmReady[`GF_PM_READY_BITS-1:0])) begin
            pmReady <= '0;
            readyDelay <= takeBits(2);
            if (pmCommand[`GF_PM_TIMER] && pmCommandOption == `GF_OPT_TIMER2) begin
                timerDelay <= 32'd1 + takeBits(2);  // closing timer runs out later
            end
        end else if (readyDelay == 0) begin
            pmReady <= 8'hFF;
        end else begin
            readyDelay <= readyDelay - 1;
        end
        pmLastStep <= (timerDelay == 1) ? (8'b1 << `GF_PM_TIMER) : 8'b0;
        if (timerDelay != 0) begin
            timerDelay <= timerDelay - 1;
        end
        if (start) begin
            beatsSent <= '0;
            readGap <= takeBits(2);
        end else if (pmReadValid && pmReadReady) begin
            if (beatsSent == 0) begin
                beat0 <= pmReadData;
            end else begin
                beat1 <= pmReadData;
            end
            beatsSent <= beatsSent + 1;
            pmReadValid <= 1'b0;
            readGap <= takeBits(2);
        end else if (!pmReadValid && beatsSent < 2) begin
            if (readGap == 0) begin
                pmReadValid <= 1'b1;
                pmReadData <= takeBits(32);
            end else begin
                readGap <= readGap - 1;
            end
        end
        readReady <= (takeBits(2) != 0);
    end

    // checks on the PM steps and the read beat
    always @(posedge iSystemClock) begin
        if (!iReset) begin
            if (start) begin
                assert (commandMatches) else reportMismatch("start on mismatch", 0, 1);
                stepIndex <= 0;
            end
            if (pmCommand != '0 && (&pmReady[`GF_PM_READY_BITS-1:0])) begin
                case (stepIndex)
                    0: begin
                        expCommand = 8'b1 << `GF_PM_CAL;
                        expOption = 3'b000;
                        expCount = expLun ? 16'd2 : 16'd1;
                        afterCal <= 1;
                    end
                    1: begin
                        expCommand = 8'b1 << `GF_PM_TIMER;
                        expOption = `GF_OPT_CE_ON;
                        expCount = 16'd149;
                    end
                    2: begin
                        expCommand = 8'b1 << `GF_PM_DATA_IN;
                        expOption = `GF_OPT_BYTE_IN;
                        expCount = 16'd7;
                    end
                    default: begin
                        expCommand = 8'b1 << `GF_PM_TIMER;
                        expOption = 3'b100;
                        expCount = 16'd3;
                    end
                endcase
                assert (pmCommand == expCommand)
                    else reportMismatch("step command", 32'(expCommand), 32'(pmCommand));
                assert (pmCommandOption == expOption)
                    else reportMismatch("step option", 32'(expOption), 32'(pmCommandOption));
                assert (pmNumOfData == expCount)
                    else reportMismatch("step count", 32'(expCount), 32'(pmNumOfData));
                assert (pmTargetWay == expWay)
                    else reportMismatch("target way", 32'(expWay), 32'(pmTargetWay));
                stepIndex <= stepIndex + 1;
            end
            if (afterCal == 1) begin
                assert (pmCaData == expCmdByte && !pmCaSelect)
                    else reportMismatch("command byte", {23'b0, 1'b0, expCmdByte},
                                        {23'b0, pmCaSelect, pmCaData});
                afterCal <= 2;
            end else if (afterCal == 2) begin
                assert (pmCaData == expAddr && pmCaSelect)
                    else reportMismatch("address byte", {23'b0, 1'b1, expAddr},
                                        {23'b0, pmCaSelect, pmCaData});
                afterCal <= 0;
            end
            if (readValid && readReady) begin
                expWord = {beat1[31:24], beat1[15:8], beat0[31:24], beat0[15:8]};
                assert (readData == expWord) else reportMismatch("packed data", expWord, readData);
                assert (readLast) else reportMismatch("read last", 1, 0);
                readBeats <= readBeats + 1;
            end
        end
    end

    task automatic sendMismatch(input int index);
        logic [31:0] draw;
        @(negedge iSystemClock);
        commandMatches = 1'b0;
        draw = takeBits(6);
        @(posedge iSystemClock);
        opcode <= index[0] ? `GF_OPCODE : (`GF_OPCODE ^ (draw[5:0] | 6'b1));
        targetId <= index[0] ? (`GF_TARGET_ID ^ (draw[4:0] | 5'b1)) : `GF_TARGET_ID;
        cmdValid <= 1'b1;
        repeat (3) begin
            @(posedge iSystemClock);
            assert (cmdReady) else reportMismatch("ready on mismatch", 1, 0);
        end
        cmdValid <= 1'b0;
    endtask

    task automatic runRequest(input int index);
        logic [31:0] draw;
        @(negedge iSystemClock);
        draw = takeBits(17);
        requestIndex = index;
        commandMatches = 1'b1;
        expLun = index[0];     // alternate so both variants are covered
        expCmdByte = expLun ? `GF_FLASH_CMD_LUN : `GF_FLASH_CMD;
        expAddr = expLun ? {6'b0, draw[2:1]} : draw[12:5];
        expWay = draw[16:13];
        @(posedge iSystemClock);
        opcode <= `GF_OPCODE;
        targetId <= `GF_TARGET_ID;
        sourceId <= {draw[4:1], expLun};
        length <= draw[12:5];
        waySelect <= draw[16:13];
        cmdValid <= 1'b1;
        do @(posedge iSystemClock); while (!start);
        cmdValid <= 1'b0;
        do @(posedge iSystemClock); while (!lastStep);
        @(posedge iSystemClock);
        assert (cmdReady) else reportMismatch("ready after last", 1, 0);
        assert (stepIndex == 4) else reportMismatch("step total", 4, stepIndex);
        assert (readBeats == index + 1) else reportMismatch("read beats", index + 1, readBeats);
    endtask

    initial begin
        iReset = 1'b1;
        opcode = '0;
        targetId = '0;
        sourceId = '0;
        length = '0;
        cmdValid = 1'b0;
        waySelect = '0;
        repeat (5) @(posedge iSystemClock);
        assert ({cmdReady, readValid, readLast, pmReadReady, pmCaSelect} == 5'b0)
            else reportMismatch("reset flags", 0, {cmdReady, readValid, readLast,
                                                   pmReadReady, pmCaSelect});
        assert (pmCommand == '0) else reportMismatch("reset command", 0, 32'(pmCommand));
        iReset <= 1'b0;
        do @(posedge iSystemClock); while (!cmdReady);
        for (int n = 0; n < NumRequests; n++) begin
            if (n % 3 == 0) begin
                sendMismatch(n / 3);
            end
            runRequest(n);
        end
        repeat (4) @(posedge iSystemClock);
        if (dut.assertions.failureCount == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("Result: FAILED");
            $fatal(1, "bound assertions failed");
        end
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+logic
logic/getFeaturesPkg.sv
logic/sequencerStepIf.sv
logic/featureSequencer.sv
logic/primitiveIssuer.sv
logic/featureCollector.sv
logic/getFeaturesTop.sv
tests/getFeatures_sva.sv
tests/getFeaturesTb.sv

// File: Makefile
# Verilator build and run for the get features sequencer

VERILATOR ?= verilator
TOP       ?= getFeaturesTb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIMFLAGS  ?= +verilator+error+limit+100
PASS_TEXT ?= Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
